// File: Makefile
TOP = tb_user_io

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f project.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// File: project.f
verilog/user_io_pkg.sv
verilog/byte_collector.sv
verilog/spi_link.sv
verilog/cmd_decoder.sv
verilog/key_decoder.sv
verilog/ps2_sender.sv
verilog/user_io_top.sv
sim/user_io_assertions.sv
sim/tb_user_io.sv

// File: sim/tb_user_io.sv
module tb_user_io;

	localparam logic [31:0] SEED = 32'h739e_a74e;
	localparam int NUM_FRAMES = 60;
	// spi clock half period in clk_sys cycles
	localparam int SPI_HALF = 4;
	// one spi byte with its lead-in cycle and the crossing gap
	localparam int BYTE_CYCLES = 1 + 8 * 2 * SPI_HALF + 4;
	// command byte plus up to nine payload bytes
	localparam int MAX_BYTES = 10;
	localparam int FRAME_GAP = 40;
	// eleven ps2 clock periods plus one idle period per byte
	localparam int PS2_BYTE_CYCLES = 12 * 2 * user_io_pkg::PS2_DIV;
	localparam int PS2_DRAIN = 9 * PS2_BYTE_CYCLES;
	localparam int MAX_FRAME_CYCLES = MAX_BYTES * BYTE_CYCLES + FRAME_GAP + PS2_DRAIN;
	localparam int TIMEOUT = 10 + NUM_FRAMES * MAX_FRAME_CYCLES + PS2_DRAIN;

	logic clk_sys = 1'b0;
	logic SPI_CLK;
	logic SPI_SS_IO;
	logic SPI_MOSI;
	wire  SPI_MISO;
	logic [1:0] buttons;
	logic [1:0] switches;
	logic scandoubler_disable;
	logic ypbpr;
	logic no_csync;
	logic [6:0] core_mod;
	user_io_pkg::joystick_t  joystick_0;
	user_io_pkg::joystick_t  joystick_1;
	user_io_pkg::joystick_t  joystick_2;
	user_io_pkg::joystick_t  joystick_3;
	user_io_pkg::joystick_t  joystick_4;
	user_io_pkg::status_t    status;
	user_io_pkg::key_event_t key;
	logic key_strobe;
	logic ps2_kbd_clk;
	logic ps2_kbd_data;

	// reference model, settings start as after power up
	user_io_pkg::but_sw_t   exp_but_sw   = '0;
	logic [6:0]             exp_core_mod = 7'd1;
	user_io_pkg::joystick_t exp_joy [user_io_pkg::JOY_COUNT] = '{default: '0};
	user_io_pkg::status_t   exp_status   = '0;
	// events and bytes still expected from the dut
	user_io_pkg::key_event_t key_q [$];
	logic [7:0] ps2_q [$];
	// bytes of the frame being sent
	logic [7:0] frame_q [$];

	int err_value = 0;
	int err_other = 0;
	int n_checks  = 0;
	int cycles    = 0;

	user_io_top i_dut (.*);

	always #20 clk_sys = ~clk_sys;

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		n_checks++;
		if (act !== exp) begin
			err_value++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_but_sw(input string name, input user_io_pkg::but_sw_t exp,
		input user_io_pkg::but_sw_t act);
		n_checks++;
		if (act !== exp) begin
			err_value++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_core_mod(input string name, input logic [6:0] exp, input logic [6:0] act);
		n_checks++;
		if (act !== exp) begin
			err_value++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_joy(input string name, input user_io_pkg::joystick_t exp,
		input user_io_pkg::joystick_t act);
		n_checks++;
		if (act !== exp) begin
			err_value++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input user_io_pkg::status_t exp,
		input user_io_pkg::status_t act);
		n_checks++;
		if (act !== exp) begin
			err_value++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_key(input string name, input user_io_pkg::key_event_t exp,
		input user_io_pkg::key_event_t act);
		n_checks++;
		if (act !== exp) begin
			err_value++;
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// compare every settings output against the model
	task automatic check_settings(input string name);
		user_io_pkg::but_sw_t   act_but_sw;
		user_io_pkg::joystick_t act_joy [user_io_pkg::JOY_COUNT];
		@(negedge clk_sys);
		act_but_sw = '{unused: 1'b0, no_csync: no_csync, ypbpr: ypbpr,
			scandoubler_disable: scandoubler_disable, switches: switches, buttons: buttons};
		act_joy = '{joystick_0, joystick_1, joystick_2, joystick_3, joystick_4};
		check_but_sw({name, " but_sw"}, exp_but_sw, act_but_sw);
		check_core_mod({name, " core_mod"}, exp_core_mod, core_mod);
		check_status({name, " status"}, exp_status, status);
		for (int j = 0; j < user_io_pkg::JOY_COUNT; j++)
			check_joy($sformatf("%s joystick_%0d", name, j), exp_joy[j], act_joy[j]);
	endtask

	// one byte, mosi msb first, miso read as the spi clock rises
	task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
		@(posedge clk_sys);
		for (int i = 7; i >= 0; i--) begin
			SPI_MOSI <= tx[i];
			repeat (SPI_HALF) @(posedge clk_sys);
			rx[i] = SPI_MISO;
			SPI_CLK <= 1'b1;
			repeat (SPI_HALF) @(posedge clk_sys);
			SPI_CLK <= 1'b0;
		end
		// byte crosses into clk_sys before the next one starts
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic send_frame(input string name);
		logic [7:0] miso;
		@(posedge clk_sys);
		SPI_SS_IO <= 1'b0;
		repeat (2) @(posedge clk_sys);
		for (int b = 0; b < frame_q.size(); b++) begin
			spi_byte(frame_q[b], miso);
			// core type only during the command byte
			if (b == 0)
				check_byte({name, " miso command"}, user_io_pkg::CORE_TYPE, miso);
			else
				check_byte({name, " miso payload"}, 8'h00, miso);
		end
		@(posedge clk_sys);
		SPI_SS_IO <= 1'b1;
		repeat (FRAME_GAP) @(posedge clk_sys);
	endtask

	// builds one random frame, updates the model, sends and checks it
	task automatic run_frame(input int num);
		string name;
		int kind;
		int idx;
		int n;
		int pre;
		logic [7:0] val;
		logic pressed;
		logic ext;
		kind = $urandom % 5;
		frame_q.delete();
		case (kind)
			0: begin
				name = $sformatf("frame %0d but_sw", num);
				val = 8'($urandom);
				frame_q.push_back(user_io_pkg::CMD_BUT_SW);
				frame_q.push_back(val);
				// bit 7 is unused
				exp_but_sw = '{unused: 1'b0, no_csync: val[6], ypbpr: val[5],
					scandoubler_disable: val[4], switches: val[3:2], buttons: val[1:0]};
			end
			1: begin
				name = $sformatf("frame %0d core_mod", num);
				val = 8'($urandom);
				frame_q.push_back(user_io_pkg::CMD_CORE_MOD);
				frame_q.push_back(val);
				exp_core_mod = val[6:0];
			end
			2: begin
				idx = $urandom % user_io_pkg::JOY_COUNT;
				name = $sformatf("frame %0d joystick %0d", num, idx);
				frame_q.push_back(8'(user_io_pkg::CMD_JOY_BASE + idx));
				// little endian, first payload byte lands in bits 7:0
				for (int b = 0; b < 4; b++) begin
					val = 8'($urandom);
					frame_q.push_back(val);
					exp_joy[idx][8*b +: 8] = val;
				end
				// an extra byte now and then must be ignored
				if ($urandom % 4 == 0)
					frame_q.push_back(8'($urandom));
			end
			3: begin
				name = $sformatf("frame %0d status", num);
				frame_q.push_back(user_io_pkg::CMD_STATUS);
				for (int b = 0; b < 8; b++) begin
					val = 8'($urandom);
					frame_q.push_back(val);
					exp_status[8*b +: 8] = val;
				end
				if ($urandom % 4 == 0)
					frame_q.push_back(8'($urandom));
			end
			default: begin
				name = $sformatf("frame %0d keyboard", num);
				frame_q.push_back(user_io_pkg::CMD_KEYBOARD);
				// prefix state lasts for the whole frame
				pressed = 1'b1;
				ext = 1'b0;
				n = 1 + $urandom % 3;
				for (int k = 0; k < n; k++) begin
					pre = $urandom % 4;
					if (pre[0]) begin
						frame_q.push_back(user_io_pkg::KEY_EXTENDED_PREFIX);
						ext = 1'b1;
					end
					if (pre[1]) begin
						frame_q.push_back(user_io_pkg::KEY_BREAK_PREFIX);
						pressed = 1'b0;
					end
					val = 8'($urandom);
					// a code must not look like a prefix
					if (val == user_io_pkg::KEY_EXTENDED_PREFIX || val == user_io_pkg::KEY_BREAK_PREFIX)
						val = 8'h1c;
					frame_q.push_back(val);
					key_q.push_back('{pressed: pressed, extended: ext, code: val});
				end
				// every payload byte is replayed on ps2, prefixes too
				for (int b = 1; b < frame_q.size(); b++)
					ps2_q.push_back(frame_q[b]);
			end
		endcase
		send_frame(name);
		// let the ps2 fifo run empty so it never holds more than 8
		while (ps2_q.size() != 0)
			@(posedge clk_sys);
		check_settings(name);
	endtask

	// key events are compared in the middle of the cycle
	always @(negedge clk_sys) begin
		if (key_strobe) begin
			if (key_q.size() == 0) begin
				err_other++;
				$display("key strobe seen while no key event was expected");
			end else
				check_key("key event", key_q.pop_front(), key);
		end
	end

	// ps2 host side, data is read on the falling clock
	always begin : ps2_monitor
		logic [10:0] bits;
		for (int i = 0; i < 11; i++) begin
			@(negedge ps2_kbd_clk);
			bits[i] = ps2_kbd_data;
		end
		if (bits[0] !== 1'b0 || bits[10] !== 1'b1 || ^bits[9:1] !== 1'b1) begin
			err_other++;
			$display("ps2 frame has a bad start, parity or stop bit: %b", bits);
		end
		if (ps2_q.size() == 0) begin
			err_other++;
			$display("ps2 byte %h sent while no byte was expected", bits[8:1]);
		end else
			check_byte("ps2 byte", ps2_q.pop_front(), bits[8:1]);
	end

	// run limit from the worst case frame length
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(SEED));
		SPI_CLK   <= 1'b0;
		SPI_SS_IO <= 1'b1;
		SPI_MOSI  <= 1'b0;
		repeat (10) @(posedge clk_sys);
		check_settings("reset");
		if (key_strobe !== 1'b0 || ps2_kbd_clk !== 1'b1 || ps2_kbd_data !== 1'b1) begin
			err_other++;
			$display("keyboard outputs are not idle after reset");
		end
		for (int f = 0; f < NUM_FRAMES; f++)
			run_frame(f);
		if (key_q.size() != 0) begin
			err_other++;
			$display("%0d key events never arrived", key_q.size());
		end
		$display("checks %0d, value errors %0d, other errors %0d", n_checks, err_value, err_other);
		if (err_value + err_other == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: sim/user_io_assertions.sv
module user_io_assertions (
	input logic       clk_sys,
	input logic [3:0] tx_state,
	input logic       ps2_kbd_clk,
	input logic       ps2_kbd_data
);

	// a frame leaves idle only as the clock rises, so the line never dips early
	idle_clk_high: assert property (@(posedge clk_sys) (tx_state == 4'd0) |=> ps2_kbd_clk)
		else $error("ps2 clock low right after the sender was idle");

	// line parked high while no frame goes out
	idle_data_high: assert property (@(posedge clk_sys) (tx_state == 4'd0) |-> ps2_kbd_data)
		else $error("ps2 data low while the sender is idle");

	// state 11 is the stop bit and nothing comes after it
	state_in_range: assert property (@(posedge clk_sys) tx_state <= 4'd11)
		else $error("ps2 sender state %0d is past the stop bit", tx_state);

endmodule

bind ps2_sender user_io_assertions i_assertions (
	.clk_sys      (clk_sys),
	.tx_state     (tx_state),
	.ps2_kbd_clk  (ps2_kbd_clk),
	.ps2_kbd_data (ps2_kbd_data)
);

// File: verilog/byte_collector.sv
module byte_collector #(
	parameter type payload_t = user_io_pkg::joystick_t
) (
	input  logic                 clk_sys,
	input  user_io_pkg::spi_rx_t rx,
	output payload_t             value,
	output logic                 done
);

	localparam int WIDTH = $bits(payload_t);
	localparam int BYTES = WIDTH / 8;
	localparam int CNT_W = $clog2(BYTES + 1);

	logic [CNT_W-1:0] count = '0;
	logic [WIDTH-1:0] shreg;
	logic [WIDTH-1:0] next_shreg;

	// new byte enters at the top, first byte ends up in [7:0]
	assign next_shreg = {rx.data, shreg[WIDTH-1:8]};
	assign value      = payload_t'(next_shreg);
	// fires on the byte that fills the payload
	assign done       = rx.valid && (count == CNT_W'(BYTES - 1));

	// byte count, saturates so extra bytes are ignored
	always_ff @(posedge clk_sys) begin
		if (rx.first)
			count <= '0;
		else if (rx.valid && (count != CNT_W'(BYTES)))
			count <= count + CNT_W'(1);
	end

	always_ff @(posedge clk_sys) begin
		if (rx.valid)
			shreg <= next_shreg;
	end

endmodule

// File: verilog/cmd_decoder.sv
module cmd_decoder (
	input  logic                   clk_sys,
	input  user_io_pkg::spi_rx_t   rx,
	output user_io_pkg::but_sw_t   but_sw,
	output logic [6:0]             core_mod,
	output user_io_pkg::joystick_t joystick_0,
	output user_io_pkg::joystick_t joystick_1,
	output user_io_pkg::joystick_t joystick_2,
	output user_io_pkg::joystick_t joystick_3,
	output user_io_pkg::joystick_t joystick_4,
	output user_io_pkg::status_t   status,
	output user_io_pkg::spi_rx_t   key_rx
);

	logic [7:0] cmd     = '0;
	logic [2:0] joy_sel = '0;

	// settings keep their value from frame to frame
	user_io_pkg::but_sw_t   but_sw_q   = '0;
	logic [6:0]             core_mod_q = 7'd1;
	user_io_pkg::joystick_t joy_q [user_io_pkg::JOY_COUNT] = '{default: '0};
	user_io_pkg::status_t   status_q   = '0;

	user_io_pkg::spi_rx_t   joy_rx;
	user_io_pkg::spi_rx_t   status_rx;
	user_io_pkg::joystick_t joy_value;
	user_io_pkg::status_t   status_value;
	logic frame_start;
	logic payload;
	logic is_joy;
	logic joy_done;
	logic status_done;

	assign frame_start = rx.valid && rx.first;
	assign payload     = rx.valid && !rx.first;
	assign is_joy      = (cmd >= user_io_pkg::CMD_JOY_BASE) && (cmd <= user_io_pkg::CMD_JOY_LAST);

	// every consumer sees the frame start, payload only goes to the owner
	assign joy_rx    = '{valid: payload && is_joy, first: frame_start, data: rx.data};
	assign status_rx = '{valid: payload && (cmd == user_io_pkg::CMD_STATUS),
		first: frame_start, data: rx.data};
	assign key_rx    = '{valid: payload && (cmd == user_io_pkg::CMD_KEYBOARD),
		first: frame_start, data: rx.data};

	byte_collector #(.payload_t(user_io_pkg::joystick_t)) i_joy_collector (
		.clk_sys (clk_sys),
		.rx      (joy_rx),
		.value   (joy_value),
		.done    (joy_done)
	);

	byte_collector #(.payload_t(user_io_pkg::status_t)) i_status_collector (
		.clk_sys (clk_sys),
		.rx      (status_rx),
		.value   (status_value),
		.done    (status_done)
	);

	always_ff @(posedge clk_sys) begin
		if (frame_start) begin
			cmd <= rx.data;
			// joystick index, only meaningful for 0x60..0x64
			joy_sel <= 3'(rx.data - user_io_pkg::CMD_JOY_BASE);
		end else if (payload) begin
			// single byte settings are written straight away
			case (cmd)
				user_io_pkg::CMD_BUT_SW:   but_sw_q   <= user_io_pkg::but_sw_t'(rx.data);
				user_io_pkg::CMD_CORE_MOD: core_mod_q <= rx.data[6:0];
				default: ;
			endcase
		end
		if (joy_done)
			joy_q[joy_sel] <= joy_value;
		if (status_done)
			status_q <= status_value;
	end

	assign but_sw     = but_sw_q;
	assign core_mod   = core_mod_q;
	assign status     = status_q;
	assign joystick_0 = joy_q[0];
	assign joystick_1 = joy_q[1];
	assign joystick_2 = joy_q[2];
	assign joystick_3 = joy_q[3];
	assign joystick_4 = joy_q[4];

endmodule

// File: verilog/key_decoder.sv
module key_decoder (
	input  logic                    clk_sys,
	input  user_io_pkg::spi_rx_t    key_rx,
	output user_io_pkg::key_event_t key,
	output logic                    key_strobe,
	output logic                    push_valid,
	output logic [7:0]              push_data
);

	// prefix state within the current frame
	logic pressed  = 1'b1;
	logic extended = 1'b0;

	user_io_pkg::key_event_t key_q = '0;
	logic       strobe_q     = 1'b0;
	logic       push_valid_q = 1'b0;
	logic [7:0] push_data_q;

	always_ff @(posedge clk_sys) begin
		strobe_q     <= 1'b0;
		// raw bytes go to the ps2 port unchanged, prefixes included
		push_valid_q <= key_rx.valid;
		push_data_q  <= key_rx.data;
		if (key_rx.first) begin
			pressed  <= 1'b1;
			extended <= 1'b0;
		end else if (key_rx.valid) begin
			if (key_rx.data == user_io_pkg::KEY_EXTENDED_PREFIX)
				extended <= 1'b1;
			else if (key_rx.data == user_io_pkg::KEY_BREAK_PREFIX)
				pressed <= 1'b0;
			else begin
				// plain code byte ends the event
				key_q    <= '{pressed: pressed, extended: extended, code: key_rx.data};
				strobe_q <= 1'b1;
			end
		end
	end

	assign key        = key_q;
	assign key_strobe = strobe_q;
	assign push_valid = push_valid_q;
	assign push_data  = push_data_q;

endmodule

// File: verilog/ps2_sender.sv
module ps2_sender (
	input  logic       clk_sys,
	input  logic       push_valid,
	input  logic [7:0] push_data,
	output logic       ps2_kbd_clk,
	output logic       ps2_kbd_data
);

	localparam int PTR_W = $clog2(user_io_pkg::PS2_FIFO_DEPTH);
	localparam int DIV_W = $clog2(user_io_pkg::PS2_DIV + 1);

	// fifo, pointers carry one extra wrap bit
	logic [7:0]   fifo [user_io_pkg::PS2_FIFO_DEPTH];
	logic [PTR_W:0] wptr = '0;
	logic [PTR_W:0] rptr = '0;
	logic fifo_empty;
	logic fifo_full;

	// free running ps2 clock
	logic [DIV_W-1:0] div_cnt = '0;
	logic ps2_clk = 1'b0;
	logic clk_rise;

	// 0 idle, 1 start, 2..9 data, 10 parity, 11 stop
	logic [3:0] tx_state = 4'd0;
	logic [7:0] tx_byte;
	logic       tx_parity;
	logic       data_q = 1'b1;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[PTR_W-1:0] == rptr[PTR_W-1:0]) && (wptr[PTR_W] != rptr[PTR_W]);

	// a push into a full fifo is dropped
	always_ff @(posedge clk_sys) begin
		if (push_valid && !fifo_full) begin
			fifo[wptr[PTR_W-1:0]] <= push_data;
			wptr <= wptr + 1'b1;
		end
	end

	assign clk_rise = (div_cnt == DIV_W'(user_io_pkg::PS2_DIV - 1)) && !ps2_clk;

	always_ff @(posedge clk_sys) begin
		if (div_cnt == DIV_W'(user_io_pkg::PS2_DIV - 1)) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else
			div_cnt <= div_cnt + DIV_W'(1);
	end

	// every step happens on the rising ps2 edge, host samples on falling
	always_ff @(posedge clk_sys) begin
		if (clk_rise) begin
			case (tx_state)
				4'd0: if (!fifo_empty) begin
					tx_byte   <= fifo[rptr[PTR_W-1:0]];
					rptr      <= rptr + 1'b1;
					// odd parity, starts at one
					tx_parity <= 1'b1;
					data_q    <= 1'b0;
					tx_state  <= 4'd1;
				end
				4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8: begin
					// lsb first
					data_q    <= tx_byte[0];
					tx_byte   <= {1'b0, tx_byte[7:1]};
					tx_parity <= tx_parity ^ tx_byte[0];
					tx_state  <= tx_state + 4'd1;
				end
				4'd9: begin
					data_q   <= tx_parity;
					tx_state <= 4'd10;
				end
				4'd10: begin
					data_q   <= 1'b1;
					tx_state <= 4'd11;
				end
				default: tx_state <= 4'd0;
			endcase
		end
	end

	// clock is parked high while nothing is sent
	assign ps2_kbd_clk  = ps2_clk || (tx_state == 4'd0);
	assign ps2_kbd_data = data_q;

endmodule

// File: verilog/spi_link.sv
module spi_link (
	input  logic                 clk_sys,
	input  logic                 SPI_CLK,
	input  logic                 SPI_SS_IO,
	input  logic                 SPI_MOSI,
	output logic                 SPI_MISO,
	output user_io_pkg::spi_rx_t rx
);

	// spi clock domain
	logic [2:0] bit_cnt;
	logic       byte_zero;
	logic [6:0] sbuf;
	logic       miso_q;
	// last full byte, held stable until the next one
	logic [7:0] rx_byte;
	logic       rx_first;
	// flips once per byte, survives frame select
	logic       rx_toggle = 1'b0;

	// clk_sys domain
	logic tog_meta = 1'b0;
	logic tog_sync = 1'b0;
	logic tog_prev = 1'b0;
	user_io_pkg::spi_rx_t rx_q = '0;

	// bit counter, byte 0 flag
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt   <= 3'd0;
			byte_zero <= 1'b1;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7)
				byte_zero <= 1'b0;
		end
	end

	// mosi shift, msb first
	always_ff @(posedge SPI_CLK) begin
		sbuf <= {sbuf[5:0], SPI_MOSI};
		if (bit_cnt == 3'd7) begin
			rx_byte   <= {sbuf, SPI_MOSI};
			rx_first  <= byte_zero;
			rx_toggle <= ~rx_toggle;
		end
	end

	// miso moves on the falling edge, bit 7 is preset while deselected
	always_ff @(negedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			miso_q <= user_io_pkg::CORE_TYPE[7];
		else if (byte_zero)
			miso_q <= user_io_pkg::CORE_TYPE[~bit_cnt];
		else
			miso_q <= 1'b0;
	end

	assign SPI_MISO = SPI_SS_IO ? 1'bz : miso_q;

	// two flop sync of the toggle, third flop finds the edge
	always_ff @(posedge clk_sys) begin
		tog_meta <= rx_toggle;
		tog_sync <= tog_meta;
		tog_prev <= tog_sync;
		rx_q.valid <= tog_sync ^ tog_prev;
		// byte was latched cycles ago, safe to sample here
		rx_q.first <= rx_first;
		rx_q.data  <= rx_byte;
	end

	assign rx = rx_q;

endmodule

// File: verilog/user_io_pkg.sv
package user_io_pkg;

	// command codes, first byte of every SPI frame
	localparam logic [7:0] CMD_BUT_SW   = 8'h01;
	localparam logic [7:0] CMD_KEYBOARD = 8'h05;
	localparam logic [7:0] CMD_STATUS   = 8'h1e;
	localparam logic [7:0] CMD_CORE_MOD = 8'h21;
	localparam logic [7:0] CMD_JOY_BASE = 8'h60;
	localparam logic [7:0] CMD_JOY_LAST = 8'h64;

	// answer shifted out on MISO while the command byte comes in
	localparam logic [7:0] CORE_TYPE = 8'ha4;

	localparam int JOY_COUNT = 5;

	// clk_sys cycles per half period of the emulated keyboard clock
	localparam int PS2_DIV        = 4;
	localparam int PS2_FIFO_DEPTH = 8;

	// scan code prefixes
	localparam logic [7:0] KEY_EXTENDED_PREFIX = 8'he0;
	localparam logic [7:0] KEY_BREAK_PREFIX    = 8'hf0;

	// payload byte of command 0x01
	typedef struct packed {
		logic       unused;
		logic       no_csync;
		logic       ypbpr;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} but_sw_t;

	typedef logic [31:0] joystick_t;
	typedef logic [63:0] status_t;

	// one received byte in the clk_sys domain
	// first marks the command byte of a frame
	typedef struct packed {
		logic       valid;
		logic       first;
		logic [7:0] data;
	} spi_rx_t;

	typedef struct packed {
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

endpackage

// File: verilog/user_io_top.sv
module user_io_top (
	input  logic                    clk_sys,
	input  logic                    SPI_CLK,
	input  logic                    SPI_SS_IO,
	input  logic                    SPI_MOSI,
	output logic                    SPI_MISO,
	output logic [1:0]              buttons,
	output logic [1:0]              switches,
	output logic                    scandoubler_disable,
	output logic                    ypbpr,
	output logic                    no_csync,
	output logic [6:0]              core_mod,
	output user_io_pkg::joystick_t  joystick_0,
	output user_io_pkg::joystick_t  joystick_1,
	output user_io_pkg::joystick_t  joystick_2,
	output user_io_pkg::joystick_t  joystick_3,
	output user_io_pkg::joystick_t  joystick_4,
	output user_io_pkg::status_t    status,
	output user_io_pkg::key_event_t key,
	output logic                    key_strobe,
	output logic                    ps2_kbd_clk,
	output logic                    ps2_kbd_data
);

	user_io_pkg::spi_rx_t rx;
	user_io_pkg::spi_rx_t key_rx;
	user_io_pkg::but_sw_t but_sw;
	logic       push_valid;
	logic [7:0] push_data;

	// spi bits in, bytes out in clk_sys
	spi_link i_spi_link (
		.clk_sys   (clk_sys),
		.SPI_CLK   (SPI_CLK),
		.SPI_SS_IO (SPI_SS_IO),
		.SPI_MOSI  (SPI_MOSI),
		.SPI_MISO  (SPI_MISO),
		.rx        (rx)
	);

	cmd_decoder i_cmd_decoder (
		.clk_sys    (clk_sys),
		.rx         (rx),
		.but_sw     (but_sw),
		.core_mod   (core_mod),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joystick_2 (joystick_2),
		.joystick_3 (joystick_3),
		.joystick_4 (joystick_4),
		.status     (status),
		.key_rx     (key_rx)
	);

	key_decoder i_key_decoder (
		.clk_sys    (clk_sys),
		.key_rx     (key_rx),
		.key        (key),
		.key_strobe (key_strobe),
		.push_valid (push_valid),
		.push_data  (push_data)
	);

	// keyboard bytes are replayed on the ps2 port
	ps2_sender i_ps2_sender (
		.clk_sys      (clk_sys),
		.push_valid   (push_valid),
		.push_data    (push_data),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data)
	);

	// board pins from the 0x01 byte
	assign buttons             = but_sw.buttons;
	assign switches            = but_sw.switches;
	assign scandoubler_disable = but_sw.scandoubler_disable;
	assign ypbpr               = but_sw.ypbpr;
	assign no_csync            = but_sw.no_csync;

endmodule
